//--- tests/apple1_stimulus.txt
# columns: byte sent, echo expected (1) or rejected (0), expected echo byte, all hex
# the last eight lines are sent back to back with the minimum idle gap
41 1 41
5a 1 5a
30 1 30
39 1 39
20 1 20
21 1 21
7e 1 7e
0d 1 0d
61 1 41
7a 1 5a
6d 1 4d
00 0 00
7f 0 00
1b 0 00
48 1 48
65 1 45
0a 0 00
6c 1 4c
80 0 00
6f 1 4f
ff 0 00
5f 1 5f

//--- vlog.f
common/apple1_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
rtl/pia_6820.sv
rtl/echo_monitor.sv
rtl/segment_display.sv
rtl/apple1_de0_top.sv
tests/tb_apple1.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator from the project root and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_apple1 \
    -f vlog.f > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_apple1 > sim.log 2>&1
cat sim.log
grep -qx "TESTS PASSED" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- tests/tb_apple1.sv
// run from the project root so tests/apple1_stimulus.txt is found; the DUT runs at 16 clocks per bit
`default_nettype none

module tb_apple1;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clks_per_bit = 16;
    // trailing stimulus lines that go out with the shortest idle gap
    localparam int burst_lines  = 8;
    localparam int max_lines    = 64;
    localparam int min_gap      = 2;
    localparam int max_gap      = 40;

    logic       CLOCK_50;
    logic [2:0] BUTTON;
    logic       UART_RXD;
    logic       UART_TXD;
    logic       UART_CTS;
    logic [7:0] LEDG;
    logic [6:0] HEX0_D;
    logic [6:0] HEX1_D;
    logic [6:0] HEX2_D;
    logic [6:0] HEX3_D;

    logic [7:0] sent_mem [max_lines];
    logic       echo_mem [max_lines];
    logic [7:0] exp_mem  [max_lines];
    logic [7:0] exp_q [$];
    logic [7:0] got_q [$];
    logic [7:0] last_echo;
    int         n_lines;
    int         n_drop;
    int         errors;
    int         checks;
    int         cycles;
    int         limit;

    apple1_de0_top #(.clks_per_bit(clks_per_bit)) apple1_de0_top_i (
        .CLOCK_50 (CLOCK_50),
        .BUTTON   (BUTTON),
        .UART_RXD (UART_RXD),
        .UART_TXD (UART_TXD),
        .UART_CTS (UART_CTS),
        .LEDG     (LEDG),
        .HEX0_D   (HEX0_D),
        .HEX1_D   (HEX1_D),
        .HEX2_D   (HEX2_D),
        .HEX3_D   (HEX3_D)
    );

    // 8 ns period
    initial
    begin
        CLOCK_50 = 1'b0;
    end

    always #4 CLOCK_50 = ~CLOCK_50;

    //////////////////////////////
    // helpers
    //////////////////////////////

    // standard gfedcba segment table lit high and inverted for the active-low DE0 digits
    function automatic logic [6:0] seg_pattern(input logic [3:0] d);
        logic [6:0] lit;
        case (d)
            4'h0: lit = 7'h3f;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5b;
            4'h3: lit = 7'h4f;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6d;
            4'h6: lit = 7'h7d;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7f;
            4'h9: lit = 7'h6f;
            4'ha: lit = 7'h77;
            4'hb: lit = 7'h7c;
            4'hc: lit = 7'h39;
            4'hd: lit = 7'h5e;
            4'he: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("ERROR %0t: %s expected %0h got %0h", $time, what, exp, act);
        end
    endtask

    // skips comment lines and returns the number of test bytes read
    function automatic int load_stimulus();
        int         fd;
        int         got;
        int         count;
        string      line;
        logic [7:0] sent;
        logic [7:0] flag;
        logic [7:0] echo;
        count = 0;
        fd = $fopen("tests/apple1_stimulus.txt", "r");
        if (fd == 0)
            return 0;
        while ($fgets(line, fd) > 0 && count < max_lines)
        begin
            if (line.len() < 5 || line.getc(0) == "#")
                continue;
            got = $sscanf(line, "%h %h %h", sent, flag, echo);
            if (got == 3)
            begin
                sent_mem[count] = sent;
                echo_mem[count] = flag[0];
                exp_mem[count]  = echo;
                count++;
            end
        end
        $fclose(fd);
        return count;
    endfunction

    // one bit time with the line changing 1 ns after the rising edge
    task automatic drive_bit(input logic b);
        @(posedge CLOCK_50);
        #1 UART_RXD = b;
        repeat (clks_per_bit - 1) @(posedge CLOCK_50);
    endtask

    // 8N1 frame sent lsb first
    task automatic send_frame(input logic [7:0] b);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++)
            drive_bit(b[i]);
        drive_bit(1'b1);
    endtask

    task automatic end_run();
        $display("checks: %0d, errors: %0d, echoes received: %0d", checks, errors, got_q.size());
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    endtask

    //////////////////////////////
    // echo receiver
    //////////////////////////////

    // decodes UART_TXD at mid-bit on falling clock edges where the line is settled
    initial
    begin : txd_monitor
        logic [7:0] rx_byte;
        wait (BUTTON[0] === 1'b1);
        forever
        begin
            @(negedge CLOCK_50);
            if (UART_TXD === 1'b0)
            begin
                repeat (clks_per_bit / 2) @(negedge CLOCK_50);
                for (int k = 0; k < 8; k++)
                begin
                    repeat (clks_per_bit) @(negedge CLOCK_50);
                    rx_byte[k] = UART_TXD;
                end
                repeat (clks_per_bit) @(negedge CLOCK_50);
                if (UART_TXD !== 1'b1)
                begin
                    errors++;
                    $display("echo byte %0h at %0t has no stop bit", rx_byte, $time);
                end
                got_q.push_back(rx_byte);
            end
        end
    end

    // cycle counter whose limit is set once the stimulus length is known
    initial
    begin : watchdog
        cycles = 0;
        while (limit == 0 || cycles < limit)
        begin
            @(posedge CLOCK_50);
            cycles++;
        end
        errors++;
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        end_run();
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    task automatic run_tests();
        int gap;
        // reset low for three cycles
        repeat (3) @(posedge CLOCK_50);
        #1 BUTTON = 3'b111;
        @(negedge CLOCK_50);
        check_value("UART_TXD idle after reset", 1, UART_TXD);
        check_value("UART_CTS held low", 0, UART_CTS);
        check_value("LEDG after reset", 0, LEDG);
        check_value("HEX0_D after reset", seg_pattern(4'h0), HEX0_D);
        check_value("HEX1_D after reset", seg_pattern(4'h0), HEX1_D);
        check_value("HEX2_D after reset", seg_pattern(4'h0), HEX2_D);
        check_value("HEX3_D after reset", seg_pattern(4'h0), HEX3_D);
        for (int i = 0; i < n_lines; i++)
        begin
            send_frame(sent_mem[i]);
            // final burst leans on the display busy bit
            if (i >= n_lines - burst_lines)
                gap = min_gap;
            else
                gap = min_gap + int'($urandom % (max_gap - min_gap + 1));
            repeat (gap) drive_bit(1'b1);
        end
        @(negedge CLOCK_50);
        check_value("LEDG rejected byte count", n_drop % 256, LEDG);
        while (got_q.size() < exp_q.size())
            @(posedge CLOCK_50);
        // room for one more frame that must not come
        repeat (20 * clks_per_bit) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        check_value("number of echoes", exp_q.size(), got_q.size());
        for (int idx = 0; idx < exp_q.size(); idx++)
            check_value($sformatf("echo byte %0d", idx), exp_q[idx], got_q[idx]);
        check_value("HEX0_D last char", seg_pattern(last_echo[3:0]), HEX0_D);
        check_value("HEX1_D last char", seg_pattern(last_echo[7:4]), HEX1_D);
        check_value("HEX2_D echo count", seg_pattern(4'(exp_q.size() % 16)), HEX2_D);
        check_value("HEX3_D echo count", seg_pattern(4'((exp_q.size() / 16) % 16)), HEX3_D);
    endtask

    initial
    begin : main
        BUTTON   = 3'b110;
        UART_RXD = 1'b1;
        errors   = 0;
        checks   = 0;
        limit    = 0;
        n_drop   = 0;
        last_echo = 8'h00;
        void'($urandom(32'hdcbc));
        n_lines = load_stimulus();
        for (int i = 0; i < n_lines; i++)
        begin
            if (echo_mem[i])
            begin
                exp_q.push_back(exp_mem[i]);
                last_echo = exp_mem[i];
            end
            else
                n_drop++;
        end
        if (n_lines == 0)
        begin
            errors++;
            $display("no test bytes could be read from tests/apple1_stimulus.txt");
        end
        else
        begin
            // twice the two frames plus the longest gap per byte
            limit = n_lines * (2 * 10 + max_gap) * clks_per_bit * 2;
            run_tests();
        end
        end_run();
    end

endmodule

`default_nettype wire

//--- rtl/apple1_de0_top.sv
// DE0 top for the Apple 1 terminal echo path; BUTTON[0] is reset, BUTTON[2:1] are unused
`default_nettype none

module apple1_de0_top
    import apple1_pkg::*;
#(
    // 115200 baud from 50 MHz
    parameter int clks_per_bit = 434
) (
    input  wire        CLOCK_50,
    input  wire  [2:0] BUTTON,
    input  wire        UART_RXD,
    output logic       UART_TXD,
    output logic       UART_CTS,
    output logic [7:0] LEDG,
    output logic [6:0] HEX0_D,
    output logic [6:0] HEX1_D,
    output logic [6:0] HEX2_D,
    output logic [6:0] HEX3_D
);

    logic       rst_n;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       key_drop;
    logic       req;
    bus_req_t   req_data;
    logic       ack;
    logic [7:0] rdata;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;
    logic [7:0] last_char;
    logic [7:0] echo_count;
    logic       dsp_wr_q;
    logic [7:0] drop_cnt;

    assign rst_n    = BUTTON[0];
    // the host may always send
    assign UART_CTS = 1'b0;
    assign LEDG     = drop_cnt;

    //////////////////////////////
    // serial and bus
    //////////////////////////////

    uart_rx #(.clks_per_bit(clks_per_bit)) uart_rx_i (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .rxd      (UART_RXD),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    uart_tx #(.clks_per_bit(clks_per_bit)) uart_tx_i (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .txd      (UART_TXD)
    );

    pia_6820 pia_i (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .key_drop (key_drop),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rdata    (rdata),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy)
    );

    echo_monitor monitor_i (
        .CLOCK_50   (CLOCK_50),
        .rst_n      (rst_n),
        .req        (req),
        .req_data   (req_data),
        .ack        (ack),
        .rdata      (rdata),
        .last_char  (last_char),
        .echo_count (echo_count)
    );

    // display write strobe, one cycle late so last_char has settled
    always_ff @(posedge CLOCK_50 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dsp_wr_q <= 1'b0;
            drop_cnt <= 8'h00;
        end
        else
        begin
            dsp_wr_q <= req && ack && req_data.write && req_data.addr == dsp_addr;
            if (key_drop)
                drop_cnt <= drop_cnt + 8'd1;
        end
    end

    //////////////////////////////
    // digits
    //////////////////////////////

    segment_display seg0_i (.CLOCK_50(CLOCK_50), .rst_n(rst_n), .latch(dsp_wr_q),
                            .hexdigit(last_char[3:0]), .segments(HEX0_D));
    segment_display seg1_i (.CLOCK_50(CLOCK_50), .rst_n(rst_n), .latch(dsp_wr_q),
                            .hexdigit(last_char[7:4]), .segments(HEX1_D));
    segment_display seg2_i (.CLOCK_50(CLOCK_50), .rst_n(rst_n), .latch(dsp_wr_q),
                            .hexdigit(echo_count[3:0]), .segments(HEX2_D));
    segment_display seg3_i (.CLOCK_50(CLOCK_50), .rst_n(rst_n), .latch(dsp_wr_q),
                            .hexdigit(echo_count[7:4]), .segments(HEX3_D));

endmodule

`default_nettype wire

//--- rtl/segment_display.sv
// hex digit to DE0 seven-segment pattern, active low, shows 0 after reset
`default_nettype none

module segment_display (
    input  wire        CLOCK_50,
    input  wire        rst_n,
    input  wire        latch,
    input  wire  [3:0] hexdigit,
    output logic [6:0] segments
);

    logic [6:0] pattern;

    // bit order g f e d c b a
    always_comb
    begin
        case (hexdigit)
            4'h0: pattern = 7'h40;
            4'h1: pattern = 7'h79;
            4'h2: pattern = 7'h24;
            4'h3: pattern = 7'h30;
            4'h4: pattern = 7'h19;
            4'h5: pattern = 7'h12;
            4'h6: pattern = 7'h02;
            4'h7: pattern = 7'h78;
            4'h8: pattern = 7'h00;
            4'h9: pattern = 7'h10;
            4'ha: pattern = 7'h08;
            4'hb: pattern = 7'h03;
            4'hc: pattern = 7'h46;
            4'hd: pattern = 7'h21;
            4'he: pattern = 7'h06;
            default: pattern = 7'h0e;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n)
    begin
        if (!rst_n)
            segments <= 7'h40;
        else if (latch)
            segments <= pattern;
    end

endmodule

`default_nettype wire

//--- rtl/echo_monitor.sv
// stand-in for the Woz monitor echo loop; talks to one slave over a four-phase req/ack bus
`default_nettype none

module echo_monitor
    import apple1_pkg::*;
(
    input  wire        CLOCK_50,
    input  wire        rst_n,
    output logic       req,
    output bus_req_t   req_data,
    input  wire        ack,
    input  wire  [7:0] rdata,
    output logic [7:0] last_char,
    output logic [7:0] echo_count
);

    mon_state_t state;
    mon_state_t ret_state;
    logic [7:0] key;

    // request follows the state, so it cannot move while req is high
    always_comb
    begin
        req_data.write = 1'b0;
        req_data.wdata = 8'h00;
        case (state)
            read_kbd:
                req_data.addr = kbd_addr;
            poll_dsp:
                req_data.addr = dsp_addr;
            write_dsp:
            begin
                req_data.addr  = dsp_addr;
                req_data.write = 1'b1;
                req_data.wdata = {1'b0, key[6:0]};
            end
            default:
                req_data.addr = kbdcr_addr;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= poll_cr;
            ret_state  <= poll_cr;
            req        <= 1'b0;
            last_char  <= 8'h00;
            echo_count <= 8'h00;
        end
        else if (state == release_bus)
        begin
            // wait for the slave to drop ack
            if (!ack)
                state <= ret_state;
        end
        else if (!req)
        begin
            req <= 1'b1;
        end
        else if (ack)
        begin
            req   <= 1'b0;
            state <= release_bus;
            case (state)
                // strobe set means a key is waiting
                poll_cr:
                    ret_state <= rdata[7] ? read_kbd : poll_cr;
                read_kbd:
                    ret_state <= poll_dsp;
                poll_dsp:
                    ret_state <= rdata[7] ? poll_dsp : write_dsp;
                default:
                begin
                    ret_state  <= poll_cr;
                    last_char  <= {1'b0, key[6:0]};
                    echo_count <= echo_count + 8'd1;
                end
            endcase
        end
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (state == read_kbd && req && ack)
            key <= rdata;
    end

    a_req_stable: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        req && $past(req) |-> $stable(req_data));

endmodule

`default_nettype wire

//--- rtl/pia_6820.sv
// keyboard and display ports of an Apple 1 style PIA; only 0x20..0x7E and CR are kept as keys
`default_nettype none

module pia_6820
    import apple1_pkg::*;
(
    input  wire        CLOCK_50,
    input  wire        rst_n,
    input  wire  [7:0] rx_data,
    input  wire        rx_valid,
    output logic       key_drop,
    input  wire        req,
    input  bus_req_t   req_data,
    output logic       ack,
    output logic [7:0] rdata,
    output logic [7:0] tx_data,
    output logic       tx_start,
    input  wire        tx_busy
);

    logic [7:0] kbd_reg;
    logic [7:0] dsp_reg;
    logic [7:0] folded;
    logic       strobe;
    logic       dsp_pending;
    logic       dsp_busy;
    logic       accept;
    logic       lower;
    logic       access;

    //////////////////////////////
    // key filter
    //////////////////////////////

    assign accept = (rx_data >= 8'h20 && rx_data <= 8'h7e) || rx_data == char_cr;
    assign lower  = (rx_data >= 8'h61 && rx_data <= 8'h7a);
    // apple 1 has upper case only
    assign folded = lower ? rx_data - 8'h20 : rx_data;

    // first cycle of a bus access
    assign access   = req && !ack;
    // busy also covers a byte still on its way into the transmitter
    assign dsp_busy = tx_busy | dsp_pending | tx_start;
    assign tx_data  = dsp_reg;

    always_ff @(posedge CLOCK_50 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            strobe      <= 1'b0;
            key_drop    <= 1'b0;
            ack         <= 1'b0;
            dsp_pending <= 1'b0;
            tx_start    <= 1'b0;
        end
        else
        begin
            key_drop <= rx_valid && !accept;
            tx_start <= 1'b0;
            // hand the display byte over once the transmitter is free
            if (dsp_pending && !tx_busy && !tx_start)
            begin
                tx_start    <= 1'b1;
                dsp_pending <= 1'b0;
            end
            // four-phase handshake where ack follows req by one cycle
            if (access)
            begin
                ack <= 1'b1;
                if (req_data.write && req_data.addr == dsp_addr)
                    dsp_pending <= 1'b1;
                if (!req_data.write && req_data.addr == kbd_addr)
                    strobe <= 1'b0;
            end
            else if (!req && ack)
            begin
                ack <= 1'b0;
            end
            // a new key wins over a clearing read in the same cycle
            if (rx_valid && accept)
                strobe <= 1'b1;
        end
    end

    //////////////////////////////
    // data registers
    //////////////////////////////

    always_ff @(posedge CLOCK_50)
    begin
        // overwrites an unread key like the Apple 1 PIA
        if (rx_valid && accept)
            kbd_reg <= {1'b1, folded[6:0]};
        if (access && req_data.write && req_data.addr == dsp_addr)
            dsp_reg <= req_data.wdata;
        // rdata holds while ack is high
        if (access)
        begin
            case (req_data.addr)
                kbd_addr:   rdata <= kbd_reg;
                kbdcr_addr: rdata <= {strobe, 7'b0};
                dsp_addr:   rdata <= {dsp_busy, dsp_reg[6:0]};
                default:    rdata <= 8'h00;
            endcase
        end
    end

    a_ack_rise: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        $rose(ack) |-> req);
    // master must not start the next access before ack has dropped
    a_ack_fall: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        $fell(ack) |-> !req);

endmodule

`default_nettype wire

//--- uart/uart_tx.sv
// 8N1 transmitter; tx_data is captured on tx_start and a frame takes 10 x clks_per_bit cycles
`default_nettype none

module uart_tx
    import apple1_pkg::*;
#(
    parameter int clks_per_bit = 434
) (
    input  wire        CLOCK_50,
    input  wire        rst_n,
    input  wire  [7:0] tx_data,
    input  wire        tx_start,
    output logic       tx_busy,
    output logic       txd
);

    localparam int cw = $clog2(clks_per_bit);
    localparam logic [cw-1:0] full_cnt = cw'(clks_per_bit - 1);

    tx_state_t     state;
    logic [cw-1:0] cnt;
    logic [2:0]    bit_idx;
    logic [7:0]    shift;
    logic          bit_end;

    assign tx_busy = (state != tx_st_idle);
    assign bit_end = (cnt == full_cnt);

    always_ff @(posedge CLOCK_50 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= tx_st_idle;
            cnt     <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end
        else
        begin
            cnt <= bit_end ? '0 : cnt + 1'b1;
            case (state)
                tx_st_idle:
                begin
                    cnt <= '0;
                    txd <= ~tx_start;
                    if (tx_start)
                        state <= tx_st_start;
                end
                tx_st_start:
                begin
                    if (bit_end)
                    begin
                        txd     <= shift[0];
                        bit_idx <= '0;
                        state   <= tx_st_data;
                    end
                end
                tx_st_data:
                begin
                    if (bit_end)
                    begin
                        bit_idx <= bit_idx + 1'b1;
                        // after bit 7 the line goes high for the stop bit
                        txd     <= (bit_idx == 3'd7) ? 1'b1 : shift[0];
                        if (bit_idx == 3'd7)
                            state <= tx_st_stop;
                    end
                end
                default:
                begin
                    if (bit_end)
                        state <= tx_st_idle;
                end
            endcase
        end
    end

    // shift register loads on start, then drops one bit per data bit
    always_ff @(posedge CLOCK_50)
    begin
        if (state == tx_st_idle && tx_start)
            shift <= tx_data;
        else if (bit_end && state != tx_st_idle && state != tx_st_stop)
            shift <= {1'b0, shift[7:1]};
    end

    // the adapter must wait for busy to clear before starting again
    a_no_start_busy: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        $rose(tx_start) |-> !tx_busy);

endmodule

`default_nettype wire

//--- uart/uart_rx.sv
// 8N1 receiver; clks_per_bit must be at least 4, frames with a low stop bit are dropped silently
`default_nettype none

module uart_rx
    import apple1_pkg::*;
#(
    parameter int clks_per_bit = 434
) (
    input  wire        CLOCK_50,
    input  wire        rst_n,
    input  wire        rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    localparam int cw = $clog2(clks_per_bit);
    localparam logic [cw-1:0] full_cnt = cw'(clks_per_bit - 1);
    localparam logic [cw-1:0] half_cnt = cw'(clks_per_bit / 2 - 1);

    rx_state_t   state;
    logic [1:0]  sync;
    logic [cw-1:0] cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  shift;
    logic        rxd_s;

    // two flops against metastability on the pin
    assign rxd_s   = sync[1];
    // byte stays put until the next frame starts shifting
    assign rx_data = shift;

    always_ff @(posedge CLOCK_50 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync     <= 2'b11;
            state    <= rx_st_idle;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end
        else
        begin
            sync     <= {sync[0], rxd};
            rx_valid <= 1'b0;
            cnt      <= cnt + 1'b1;
            case (state)
                rx_st_idle:
                begin
                    cnt <= '0;
                    // falling edge marks a start bit
                    if (!rxd_s)
                        state <= rx_st_start;
                end
                rx_st_start:
                begin
                    // recheck at mid start bit, a glitch goes back to idle
                    if (cnt == half_cnt)
                    begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rxd_s ? rx_st_idle : rx_st_data;
                    end
                end
                rx_st_data:
                begin
                    if (cnt == full_cnt)
                    begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= rx_st_stop;
                    end
                end
                default:
                begin
                    // mid stop bit, pulse only on a proper high stop
                    if (cnt == full_cnt)
                    begin
                        rx_valid <= rxd_s;
                        state    <= rx_st_idle;
                    end
                end
            endcase
        end
    end

    // lsb first, so shift in from the top
    always_ff @(posedge CLOCK_50)
    begin
        if (state == rx_st_data && cnt == full_cnt)
            shift <= {rxd_s, shift[7:1]};
    end

endmodule

`default_nettype wire

//--- common/apple1_pkg.sv
// shared bus, register map and state types; addresses follow the Apple 1 PIA at D010 to D012
`default_nettype none

package apple1_pkg;

    //////////////////////////////
    // register map
    //////////////////////////////

    // keyboard data, bit 7 always set once a key is stored
    localparam logic [15:0] kbd_addr   = 16'hd010;
    // keyboard control, bit 7 is the key strobe
    localparam logic [15:0] kbdcr_addr = 16'hd011;
    // display data, bit 7 reads back as busy
    localparam logic [15:0] dsp_addr   = 16'hd012;

    // carriage return is the only accepted control code
    localparam logic [7:0] char_cr = 8'h0d;

    //////////////////////////////
    // bus and state types
    //////////////////////////////

    // request from master to adapter, held stable while req is high
    typedef struct packed {
        logic [15:0] addr;
        logic        write;
        logic [7:0]  wdata;
    } bus_req_t;

    // echo loop; release_bus waits for ack to drop after each access
    typedef enum logic [2:0] {
        poll_cr,
        read_kbd,
        poll_dsp,
        write_dsp,
        release_bus
    } mon_state_t;

    typedef enum logic [1:0] {
        rx_st_idle,
        rx_st_start,
        rx_st_data,
        rx_st_stop
    } rx_state_t;

    typedef enum logic [1:0] {
        tx_st_idle,
        tx_st_start,
        tx_st_data,
        tx_st_stop
    } tx_state_t;

endpackage

`default_nettype wire
